// File: design/dhcp_client.sv
`timescale 1ns/1ps

module dhcp_client #(
  parameter net_pkg::mac_addr_t mac_addr = '0
) (
  input  logic           clk,
  input  logic           fsm_rst,
  input  logic           ipv4_req,
  input  logic [7:0]     rx_data,
  input  logic           rx_val,
  input  logic           rx_last,
  input  logic           tx_rdy,
  output net_pkg::ipv4_t ipv4_addr,
  output logic           ipv4_addr_val,
  output logic           ipv4_addr_timeout,
  output logic           busy,
  output logic [7:0]     tx_data,
  output logic           tx_val,
  output logic           tx_last
);

  logic                send;
  logic                sent;
  dhcp_pkg::dhcp_msg_t send_type;
  net_pkg::ipv4_t      req_addr;
  net_pkg::ipv4_t      srv_addr;
  logic                reply_val;
  dhcp_pkg::dhcp_msg_t reply_type;
  net_pkg::ipv4_t      reply_addr;
  net_pkg::ipv4_t      reply_srv;

  dhcp_client_fsm dhcp_client_fsm_inst (
    .clk               (clk),
    .fsm_rst           (fsm_rst),
    .ipv4_req          (ipv4_req),
    .reply_val         (reply_val),
    .reply_type        (reply_type),
    .reply_addr        (reply_addr),
    .reply_srv         (reply_srv),
    .sent              (sent),
    .send              (send),
    .send_type         (send_type),
    .req_addr          (req_addr),
    .srv_addr          (srv_addr),
    .ipv4_addr         (ipv4_addr),
    .ipv4_addr_val     (ipv4_addr_val),
    .ipv4_addr_timeout (ipv4_addr_timeout),
    .busy              (busy)
  );

  dhcp_tx_builder #(
    .mac_addr (mac_addr)
  ) dhcp_tx_builder_inst (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .send      (send),
    .send_type (send_type),
    .req_addr  (req_addr),
    .srv_addr  (srv_addr),
    .tx_rdy    (tx_rdy),
    .tx_data   (tx_data),
    .tx_val    (tx_val),
    .tx_last   (tx_last),
    .sent      (sent)
  );

  dhcp_rx_parser #(
    .mac_addr (mac_addr)
  ) dhcp_rx_parser_inst (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .rx_data    (rx_data),
    .rx_val     (rx_val),
    .rx_last    (rx_last),
    .reply_val  (reply_val),
    .reply_type (reply_type),
    .reply_addr (reply_addr),
    .reply_srv  (reply_srv)
  );

endmodule

// File: design/dhcp_client_fsm.sv
`timescale 1ns/1ps

module dhcp_client_fsm (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                ipv4_req,
  input  logic                reply_val,
  input  dhcp_pkg::dhcp_msg_t reply_type,
  input  net_pkg::ipv4_t      reply_addr,
  input  net_pkg::ipv4_t      reply_srv,
  input  logic                sent,
  output logic                send,
  output dhcp_pkg::dhcp_msg_t send_type,
  output net_pkg::ipv4_t      req_addr,
  output net_pkg::ipv4_t      srv_addr,
  output net_pkg::ipv4_t      ipv4_addr,
  output logic                ipv4_addr_val,
  output logic                ipv4_addr_timeout,
  output logic                busy
);

  typedef enum logic [2:0] {
    idle,
    send_discover,
    wait_offer,
    send_request,
    wait_ack,
    bound
  } state_t;

  state_t                          state;
  logic [dhcp_pkg::TIMER_W-1:0]    timer;
  logic [dhcp_pkg::TRY_W-1:0]      tries;
  logic                            timer_done;
  logic                            offer_ok;
  logic                            ack_ok;
  logic                            nak_ok;

  assign timer_done = (timer == dhcp_pkg::TIMER_LAST);
  assign busy       = (state != idle) && (state != bound);

  assign offer_ok = (state == wait_offer) && reply_val
                    && (reply_type == dhcp_pkg::DHCP_OFFER);
  assign ack_ok   = (state == wait_ack) && reply_val
                    && (reply_type == dhcp_pkg::DHCP_ACK);
  assign nak_ok   = (state == wait_ack) && reply_val
                    && (reply_type == dhcp_pkg::DHCP_NAK);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state             <= idle;
      send              <= 1'b0;
      send_type         <= dhcp_pkg::DHCP_DISCOVER;
      timer             <= '0;
      tries             <= '0;
      ipv4_addr_val     <= 1'b0;
      ipv4_addr_timeout <= 1'b0;
    end else begin
      send <= 1'b0;
      case (state)
        idle, bound: begin
          if (ipv4_req) begin
            ipv4_addr_val     <= 1'b0;
            ipv4_addr_timeout <= 1'b0;
            tries             <= 'd1;
            send              <= 1'b1;
            send_type         <= dhcp_pkg::DHCP_DISCOVER;
            state             <= send_discover;
          end
        end
        send_discover: begin
          if (sent) begin
            timer <= '0; // Reply window opens once the last byte is out.
            state <= wait_offer;
          end
        end
        send_request: begin
          if (sent) begin
            timer <= '0;
            state <= wait_ack;
          end
        end
        wait_offer: begin
          timer <= timer + 1'b1;
          if (offer_ok) begin
            tries     <= 'd1;
            send      <= 1'b1;
            send_type <= dhcp_pkg::DHCP_REQUEST;
            state     <= send_request;
          end else if (timer_done) begin
            if (tries == dhcp_pkg::TRY_LAST) begin
              ipv4_addr_timeout <= 1'b1;
              state             <= idle;
            end else begin
              tries <= tries + 1'b1;
              send  <= 1'b1;
              state <= send_discover;
            end
          end
        end
        wait_ack: begin
          timer <= timer + 1'b1;
          if (ack_ok) begin
            ipv4_addr_val <= 1'b1;
            state         <= bound;
          end else if (nak_ok) begin
            tries     <= 'd1; // The server refused, so start over.
            send      <= 1'b1;
            send_type <= dhcp_pkg::DHCP_DISCOVER;
            state     <= send_discover;
          end else if (timer_done) begin
            if (tries == dhcp_pkg::TRY_LAST) begin
              ipv4_addr_timeout <= 1'b1;
              state             <= idle;
            end else begin
              tries <= tries + 1'b1;
              send  <= 1'b1;
              state <= send_request;
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Lease data from the accepted OFFER, reported once the ACK arrives.
  always_ff @(posedge clk) begin
    if (offer_ok) begin
      req_addr <= reply_addr;
      srv_addr <= reply_srv;
    end
    if (ack_ok) ipv4_addr <= req_addr;
  end

endmodule

// File: design/dhcp_pkg.sv
package dhcp_pkg;

  typedef enum logic [2:0] {
    DHCP_DISCOVER = 3'd1,
    DHCP_OFFER    = 3'd2,
    DHCP_REQUEST  = 3'd3,
    DHCP_ACK      = 3'd5,
    DHCP_NAK      = 3'd6
  } dhcp_msg_t;

  localparam logic [31:0] DHCP_XID    = 32'h5a3c_e1d7;
  localparam logic [31:0] DHCP_COOKIE = 32'h6382_5363;

  localparam logic [7:0] BOOTREQUEST = 8'd1;
  localparam logic [7:0] BOOTREPLY   = 8'd2;
  localparam logic [7:0] HTYPE_ETH   = 8'd1;
  localparam logic [7:0] HLEN_ETH    = 8'd6;

  localparam logic [7:0] OPT_PAD       = 8'd0;
  localparam logic [7:0] OPT_REQ_ADDR  = 8'd50;
  localparam logic [7:0] OPT_MSG_TYPE  = 8'd53;
  localparam logic [7:0] OPT_SERVER_ID = 8'd54;
  localparam logic [7:0] OPT_END       = 8'd255;

  // Byte offsets inside the DHCP payload.
  localparam int unsigned CNT_W = 9;
  localparam logic [CNT_W-1:0] OFS_OP      = 9'd0;
  localparam logic [CNT_W-1:0] OFS_XID     = 9'd4;
  localparam logic [CNT_W-1:0] OFS_YIADDR  = 9'd16;
  localparam logic [CNT_W-1:0] OFS_CHADDR  = 9'd28;
  localparam logic [CNT_W-1:0] OFS_COOKIE  = 9'd236;
  localparam logic [CNT_W-1:0] OFS_OPTIONS = 9'd240;

  localparam logic [CNT_W-1:0] DISCOVER_LEN  = 9'd244;
  localparam logic [CNT_W-1:0] REQUEST_LEN   = 9'd256;
  localparam logic [CNT_W-1:0] MIN_REPLY_LEN = 9'd241;

  localparam int unsigned REPLY_TIMEOUT = 3000;
  localparam int unsigned MAX_TRIES     = 3;
  localparam int unsigned TIMER_W       = $clog2(REPLY_TIMEOUT);
  localparam int unsigned TRY_W         = $clog2(MAX_TRIES + 1);
  localparam logic [TIMER_W-1:0] TIMER_LAST = TIMER_W'(REPLY_TIMEOUT - 1);
  localparam logic [TRY_W-1:0]   TRY_LAST   = TRY_W'(MAX_TRIES);

  // Byte idx of a 32-bit field in network byte order.
  function automatic logic [7:0] word_byte(
    input logic [31:0] word,
    input logic [1:0]  idx
  );
    return word[31 - 8 * idx -: 8];
  endfunction

endpackage

// File: design/dhcp_rx_parser.sv
`timescale 1ns/1ps

module dhcp_rx_parser #(
  parameter net_pkg::mac_addr_t mac_addr = '0
) (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic [7:0]          rx_data,
  input  logic                rx_val,
  input  logic                rx_last,
  output logic                reply_val,
  output dhcp_pkg::dhcp_msg_t reply_type,
  output net_pkg::ipv4_t      reply_addr,
  output net_pkg::ipv4_t      reply_srv
);

  typedef enum logic [1:0] {walk_code, walk_len, walk_val, walk_end} walk_t;

  walk_t      walk;
  logic [8:0] cnt;
  logic       bad;
  logic       type_seen;
  logic [7:0] opt_code;
  logic [7:0] opt_left;
  logic       byte_bad;
  logic       type_hit;
  logic       srv_hit;
  logic [8:0] xid_rel;
  logic [8:0] chaddr_rel;
  logic [8:0] cookie_rel;
  logic [8:0] yiaddr_rel;
  logic       in_opts;

  assign xid_rel    = cnt - dhcp_pkg::OFS_XID;
  assign chaddr_rel = cnt - dhcp_pkg::OFS_CHADDR;
  assign cookie_rel = cnt - dhcp_pkg::OFS_COOKIE;
  assign yiaddr_rel = cnt - dhcp_pkg::OFS_YIADDR;
  assign in_opts    = cnt >= dhcp_pkg::OFS_OPTIONS;

  assign type_hit = rx_val && in_opts && (walk == walk_val)
                    && (opt_code == dhcp_pkg::OPT_MSG_TYPE);
  assign srv_hit  = rx_val && in_opts && (walk == walk_val)
                    && (opt_code == dhcp_pkg::OPT_SERVER_ID);

  // Check of the current byte against the fixed reply fields.
  always_comb begin
    byte_bad = 1'b0;
    if (cnt == dhcp_pkg::OFS_OP && rx_data != dhcp_pkg::BOOTREPLY) begin
      byte_bad = 1'b1;
    end
    if (cnt >= dhcp_pkg::OFS_XID && xid_rel < 9'd4 &&
        rx_data != dhcp_pkg::word_byte(dhcp_pkg::DHCP_XID, xid_rel[1:0])) begin
      byte_bad = 1'b1;
    end
    if (cnt >= dhcp_pkg::OFS_CHADDR && chaddr_rel < 9'd6 &&
        rx_data != net_pkg::mac_byte(mac_addr, chaddr_rel[2:0])) begin
      byte_bad = 1'b1;
    end
    if (cnt >= dhcp_pkg::OFS_COOKIE && cookie_rel < 9'd4 &&
        rx_data != dhcp_pkg::word_byte(dhcp_pkg::DHCP_COOKIE, cookie_rel[1:0])) begin
      byte_bad = 1'b1;
    end
    if (type_hit && rx_data[7:3] != 5'd0) begin
      byte_bad = 1'b1; // Type code outside the known range.
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      cnt       <= '0;
      bad       <= 1'b0;
      type_seen <= 1'b0;
      walk      <= walk_code;
      reply_val <= 1'b0;
    end else begin
      reply_val <= 1'b0;
      if (rx_val && rx_last) begin
        reply_val <= !bad && !byte_bad && (type_seen || type_hit)
                     && (cnt >= dhcp_pkg::MIN_REPLY_LEN - 9'd1);
        cnt       <= '0;
        bad       <= 1'b0;
        type_seen <= 1'b0;
        walk      <= walk_code;
      end else if (rx_val) begin
        if (cnt != '1) cnt <= cnt + 9'd1; // Saturates on oversized messages.
        if (byte_bad) bad <= 1'b1;
        if (type_hit) type_seen <= 1'b1;
        if (in_opts) begin
          case (walk)
            walk_code: begin
              if (rx_data == dhcp_pkg::OPT_END) begin
                walk <= walk_end;
              end else if (rx_data != dhcp_pkg::OPT_PAD) begin
                opt_code <= rx_data;
                walk     <= walk_len;
              end
            end
            walk_len: begin
              opt_left <= rx_data;
              walk     <= (rx_data == 8'd0) ? walk_code : walk_val;
            end
            walk_val: begin
              opt_left <= opt_left - 8'd1;
              if (opt_left == 8'd1) walk <= walk_code;
            end
            default: walk <= walk_end; // Everything after end is padding.
          endcase
        end
      end
    end
  end

  // The reply fields shift in as they pass; reply_val marks when they are valid.
  always_ff @(posedge clk) begin
    if (rx_val) begin
      if (cnt >= dhcp_pkg::OFS_YIADDR && yiaddr_rel < 9'd4) begin
        reply_addr <= {reply_addr[23:0], rx_data};
      end
      if (type_hit) reply_type <= dhcp_pkg::dhcp_msg_t'(rx_data[2:0]);
      if (srv_hit) reply_srv <= {reply_srv[23:0], rx_data};
    end
  end

endmodule

// File: design/dhcp_tx_builder.sv
`timescale 1ns/1ps

module dhcp_tx_builder #(
  parameter net_pkg::mac_addr_t mac_addr = '0
) (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                send,
  input  dhcp_pkg::dhcp_msg_t send_type,
  input  net_pkg::ipv4_t      req_addr,
  input  net_pkg::ipv4_t      srv_addr,
  input  logic                tx_rdy,
  output logic [7:0]          tx_data,
  output logic                tx_val,
  output logic                tx_last,
  output logic                sent
);

  logic [8:0]          cnt;
  logic [8:0]          msg_len;
  dhcp_pkg::dhcp_msg_t msg_type;
  net_pkg::ipv4_t      req_lat;
  net_pkg::ipv4_t      srv_lat;
  logic [8:0]          xid_rel;
  logic [8:0]          chaddr_rel;
  logic [8:0]          cookie_rel;
  logic [8:0]          opt_rel;
  logic                in_xid;
  logic                in_chaddr;
  logic                in_cookie;

  assign msg_len = (msg_type == dhcp_pkg::DHCP_REQUEST) ? dhcp_pkg::REQUEST_LEN
                                                        : dhcp_pkg::DISCOVER_LEN;
  assign tx_last = tx_val && (cnt == msg_len - 9'd1);

  assign xid_rel    = cnt - dhcp_pkg::OFS_XID;
  assign chaddr_rel = cnt - dhcp_pkg::OFS_CHADDR;
  assign cookie_rel = cnt - dhcp_pkg::OFS_COOKIE;
  assign opt_rel    = cnt - dhcp_pkg::OFS_OPTIONS;

  assign in_xid    = (cnt >= dhcp_pkg::OFS_XID) && (xid_rel < 9'd4);
  assign in_chaddr = (cnt >= dhcp_pkg::OFS_CHADDR) && (chaddr_rel < 9'd6);
  assign in_cookie = (cnt >= dhcp_pkg::OFS_COOKIE) && (cookie_rel < 9'd4);

  // Byte mux over the header fields and the option list.
  always_comb begin
    tx_data = 8'h00;
    if (cnt == dhcp_pkg::OFS_OP) begin
      tx_data = dhcp_pkg::BOOTREQUEST;
    end else if (cnt == dhcp_pkg::OFS_OP + 9'd1) begin
      tx_data = dhcp_pkg::HTYPE_ETH;
    end else if (cnt == dhcp_pkg::OFS_OP + 9'd2) begin
      tx_data = dhcp_pkg::HLEN_ETH;
    end else if (in_xid) begin
      tx_data = dhcp_pkg::word_byte(dhcp_pkg::DHCP_XID, xid_rel[1:0]);
    end else if (in_chaddr) begin
      tx_data = net_pkg::mac_byte(mac_addr, chaddr_rel[2:0]); // Rest of chaddr is zero.
    end else if (in_cookie) begin
      tx_data = dhcp_pkg::word_byte(dhcp_pkg::DHCP_COOKIE, cookie_rel[1:0]);
    end else if (cnt >= dhcp_pkg::OFS_OPTIONS) begin
      case (opt_rel)
        9'd0:    tx_data = dhcp_pkg::OPT_MSG_TYPE;
        9'd1:    tx_data = 8'd1;
        9'd2:    tx_data = {5'd0, msg_type};
        9'd3:    tx_data = (msg_type == dhcp_pkg::DHCP_REQUEST) ? dhcp_pkg::OPT_REQ_ADDR
                                                                : dhcp_pkg::OPT_END;
        9'd4:    tx_data = 8'd4;
        9'd5, 9'd6, 9'd7, 9'd8:
                 tx_data = dhcp_pkg::word_byte(req_lat, opt_rel[1:0] - 2'd1);
        9'd9:    tx_data = dhcp_pkg::OPT_SERVER_ID;
        9'd10:   tx_data = 8'd4;
        9'd11, 9'd12, 9'd13, 9'd14:
                 tx_data = dhcp_pkg::word_byte(srv_lat, opt_rel[1:0] - 2'd3);
        9'd15:   tx_data = dhcp_pkg::OPT_END;
        default: tx_data = 8'h00;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      tx_val <= 1'b0;
      cnt    <= '0;
      sent   <= 1'b0;
    end else begin
      sent <= tx_val && tx_rdy && tx_last; // One cycle after the final transfer.
      if (send) begin
        tx_val <= 1'b1;
        cnt    <= '0;
      end else if (tx_val && tx_rdy) begin
        if (tx_last) begin
          tx_val <= 1'b0;
        end else begin
          cnt <= cnt + 9'd1;
        end
      end
    end
  end

  // Message fields are captured at send and stay stable for the whole message.
  always_ff @(posedge clk) begin
    if (send) begin
      msg_type <= send_type;
      req_lat  <= req_addr;
      srv_lat  <= srv_addr;
    end
  end

endmodule

// File: design/net_pkg.sv
package net_pkg;

  // 48-bit Ethernet hardware address.
  typedef logic [47:0] mac_addr_t;

  // 32-bit IPv4 address, most significant byte first on the wire.
  typedef logic [31:0] ipv4_t;

  // Returns byte idx of a hardware address in transmission order.
  function automatic logic [7:0] mac_byte(
    input mac_addr_t  mac,
    input logic [2:0] idx
  );
    return mac[47 - 8 * idx -: 8];
  endfunction

endpackage

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module dhcp_client_tb -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vdhcp_client_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

exit 0

// File: src.f
design/net_pkg.sv
design/dhcp_pkg.sv
design/dhcp_tx_builder.sv
design/dhcp_rx_parser.sv
design/dhcp_client_fsm.sv
design/dhcp_client.sv
test/dhcp_client_assert.sv
test/dhcp_client_tb.sv

// File: test/dhcp_client_assert.sv
`timescale 1ns/1ps

module dhcp_client_assert (
  input logic       clk,
  input logic       fsm_rst,
  input logic       tx_rdy,
  input logic [7:0] tx_data,
  input logic       tx_val,
  input logic       tx_last,
  input logic       ipv4_addr_val,
  input logic       ipv4_addr_timeout
);

  // A stalled byte stays on the stream unchanged until it is taken.
  property tx_hold;
    @(posedge clk) disable iff (fsm_rst)
      (tx_val && !tx_rdy) |=> (tx_val && $stable(tx_data) && $stable(tx_last));
  endproperty

  assert property (tx_hold)
    else $error("tx stream changed while tx_rdy was low");

  assert property (@(posedge clk) !(ipv4_addr_val && ipv4_addr_timeout))
    else $error("address valid and timeout are high together");

  assert property (@(posedge clk) fsm_rst |=> !tx_val)
    else $error("tx_val is high right after reset");

endmodule

bind dhcp_client dhcp_client_assert dhcp_client_assert_inst (
  .clk               (clk),
  .fsm_rst           (fsm_rst),
  .tx_rdy            (tx_rdy),
  .tx_data           (tx_data),
  .tx_val            (tx_val),
  .tx_last           (tx_last),
  .ipv4_addr_val     (ipv4_addr_val),
  .ipv4_addr_timeout (ipv4_addr_timeout)
);

// File: test/dhcp_client_tb.sv
`timescale 1ns/1ps

module dhcp_client_tb;

  localparam net_pkg::mac_addr_t MAC = 48'h0200_00aa_bbcc;
  localparam int NUM_ROWS = 4;
  localparam int CYCLE_LIMIT = NUM_ROWS * dhcp_pkg::MAX_TRIES * dhcp_pkg::REPLY_TIMEOUT + 20000;

  // One server scenario per row.
  typedef struct packed {
    logic [31:0] offer;
    logic [31:0] srv;
    logic        nak;
    logic        bad_xid;
    logic        silent;
  } row_t;

  logic           clk;
  logic           fsm_rst;
  logic           ipv4_req;
  logic [7:0]     rx_data;
  logic           rx_val;
  logic           rx_last;
  logic           tx_rdy;
  net_pkg::ipv4_t ipv4_addr;
  logic           ipv4_addr_val;
  logic           ipv4_addr_timeout;
  logic           busy;
  logic [7:0]     tx_data;
  logic           tx_val;
  logic           tx_last;

  row_t       rows[NUM_ROWS];
  logic [7:0] msg[$];
  logic [7:0] ref_msg[$];
  int         cycles = 0;

  dhcp_client #(
    .mac_addr (MAC)
  ) dhcp_client_inst (
    .clk               (clk),
    .fsm_rst           (fsm_rst),
    .ipv4_req          (ipv4_req),
    .rx_data           (rx_data),
    .rx_val            (rx_val),
    .rx_last           (rx_last),
    .tx_rdy            (tx_rdy),
    .ipv4_addr         (ipv4_addr),
    .ipv4_addr_val     (ipv4_addr_val),
    .ipv4_addr_timeout (ipv4_addr_timeout),
    .busy              (busy),
    .tx_data           (tx_data),
    .tx_val            (tx_val),
    .tx_last           (tx_last)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      abort_run("timeout: the client did not finish the exchanges within the cycle limit");
    end
  end

  // Reference message made from the field layout of a client request.
  task automatic build_expected(input dhcp_pkg::dhcp_msg_t kind, input net_pkg::ipv4_t addr,
                                input net_pkg::ipv4_t srv);
    ref_msg.delete();
    for (int i = 0; i < 240; i++) ref_msg.push_back(8'h00);
    ref_msg[0] = 8'd1;
    ref_msg[1] = 8'd1;
    ref_msg[2] = 8'd6;
    for (int k = 0; k < 4; k++) begin
      ref_msg[4 + k]   = 8'(dhcp_pkg::DHCP_XID >> (24 - 8 * k));
      ref_msg[236 + k] = 8'(dhcp_pkg::DHCP_COOKIE >> (24 - 8 * k));
    end
    for (int k = 0; k < 6; k++) ref_msg[28 + k] = 8'(MAC >> (40 - 8 * k));
    ref_msg.push_back(8'd53);
    ref_msg.push_back(8'd1);
    ref_msg.push_back({5'd0, kind});
    if (kind == dhcp_pkg::DHCP_REQUEST) begin
      ref_msg.push_back(8'd50);
      ref_msg.push_back(8'd4);
      for (int k = 0; k < 4; k++) ref_msg.push_back(8'(addr >> (24 - 8 * k)));
      ref_msg.push_back(8'd54);
      ref_msg.push_back(8'd4);
      for (int k = 0; k < 4; k++) ref_msg.push_back(8'(srv >> (24 - 8 * k)));
    end
    ref_msg.push_back(8'd255);
  endtask

  // Takes bytes off the transmit stream with random stalls until tx_last.
  task automatic recv_msg();
    logic done;
    msg.delete();
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      tx_rdy = (($urandom % 4) != 0);
      if (tx_val && tx_rdy) begin
        msg.push_back(tx_data); // Taken at the next rising edge.
        done = tx_last;
      end
    end
    @(negedge clk);
    tx_rdy = 1'b0;
  endtask

  task automatic check_msg(input dhcp_pkg::dhcp_msg_t kind, input net_pkg::ipv4_t addr,
                           input net_pkg::ipv4_t srv);
    build_expected(kind, addr, srv);
    if (kind == dhcp_pkg::DHCP_REQUEST) begin
      compare("tx message length", msg.size(), dhcp_pkg::REQUEST_LEN);
    end else begin
      compare("tx message length", msg.size(), dhcp_pkg::DISCOVER_LEN);
    end
    for (int i = 0; i < ref_msg.size(); i++) begin
      compare($sformatf("tx_data[%0d]", i), msg[i], ref_msg[i]);
    end
  endtask

  task automatic send_reply(input dhcp_pkg::dhcp_msg_t kind, input net_pkg::ipv4_t addr,
                            input net_pkg::ipv4_t srv, input logic [31:0] xid);
    logic [7:0] pkt[$];
    for (int i = 0; i < 240; i++) pkt.push_back(8'h00);
    pkt[0] = 8'd2;
    pkt[1] = 8'd1;
    pkt[2] = 8'd6;
    for (int k = 0; k < 4; k++) begin
      pkt[4 + k]   = 8'(xid >> (24 - 8 * k));
      pkt[16 + k]  = 8'(addr >> (24 - 8 * k));
      pkt[236 + k] = 8'(dhcp_pkg::DHCP_COOKIE >> (24 - 8 * k));
    end
    for (int k = 0; k < 6; k++) pkt[28 + k] = 8'(MAC >> (40 - 8 * k));
    pkt.push_back(8'd53);
    pkt.push_back(8'd1);
    pkt.push_back({5'd0, kind});
    pkt.push_back(8'd0); // A pad byte between options.
    pkt.push_back(8'd54);
    pkt.push_back(8'd4);
    for (int k = 0; k < 4; k++) pkt.push_back(8'(srv >> (24 - 8 * k)));
    pkt.push_back(8'd255);
    repeat (3) @(negedge clk);
    for (int i = 0; i < pkt.size(); i++) begin
      @(negedge clk);
      rx_data = pkt[i];
      rx_val  = 1'b1;
      rx_last = (i == pkt.size() - 1);
    end
    @(negedge clk);
    rx_data = 8'h00;
    rx_val  = 1'b0;
    rx_last = 1'b0;
  endtask

  // No new message may start while the result is pending.
  task automatic wait_result();
    while (!ipv4_addr_val && !ipv4_addr_timeout) begin
      @(negedge clk);
      if (tx_val) abort_run("the client started a message while a result was due");
    end
  endtask

  task automatic run_row(input row_t r);
    int   naks;
    logic bad;
    logic done;
    naks = r.nak ? 1 : 0;
    bad  = r.bad_xid;
    done = 1'b0;
    @(negedge clk);
    ipv4_req = 1'b1;
    @(negedge clk);
    ipv4_req = 1'b0;
    compare("busy", busy, 1);
    if (r.silent) begin
      for (int t = 0; t < dhcp_pkg::MAX_TRIES; t++) begin
        recv_msg();
        check_msg(dhcp_pkg::DHCP_DISCOVER, '0, '0);
      end
      wait_result();
      compare("ipv4_addr_timeout", ipv4_addr_timeout, 1);
      compare("ipv4_addr_val", ipv4_addr_val, 0);
    end else begin
      while (!done) begin
        recv_msg();
        check_msg(dhcp_pkg::DHCP_DISCOVER, '0, '0);
        if (bad) begin
          send_reply(dhcp_pkg::DHCP_OFFER, r.offer, r.srv, dhcp_pkg::DHCP_XID ^ 32'h100);
          bad = 1'b0;
        end else begin
          send_reply(dhcp_pkg::DHCP_OFFER, r.offer, r.srv, dhcp_pkg::DHCP_XID);
          recv_msg();
          check_msg(dhcp_pkg::DHCP_REQUEST, r.offer, r.srv);
          if (naks > 0) begin
            send_reply(dhcp_pkg::DHCP_NAK, '0, r.srv, dhcp_pkg::DHCP_XID);
            naks--;
          end else begin
            send_reply(dhcp_pkg::DHCP_ACK, r.offer, r.srv, dhcp_pkg::DHCP_XID);
            done = 1'b1;
          end
        end
      end
      wait_result();
      compare("ipv4_addr_val", ipv4_addr_val, 1);
      compare("ipv4_addr_timeout", ipv4_addr_timeout, 0);
      compare("ipv4_addr", ipv4_addr, r.offer);
    end
    compare("busy", busy, 0);
  endtask

  initial begin
    void'($urandom(14876));
    fsm_rst  = 1'b1;
    ipv4_req = 1'b0;
    rx_data  = 8'h00;
    rx_val   = 1'b0;
    rx_last  = 1'b0;
    tx_rdy   = 1'b0;
    rows[0] = '{offer: 32'hc0a8_0164, srv: 32'hc0a8_0101, nak: 1'b0, bad_xid: 1'b0,
                silent: 1'b0};
    rows[1] = '{offer: 32'h0a00_002a, srv: 32'h0a00_0001, nak: 1'b1, bad_xid: 1'b0,
                silent: 1'b0};
    rows[2] = '{offer: 32'hac10_0507, srv: 32'hac10_0001, nak: 1'b0, bad_xid: 1'b1,
                silent: 1'b0};
    rows[3] = '{offer: 32'h0, srv: 32'h0, nak: 1'b0, bad_xid: 1'b0, silent: 1'b1};
    repeat (2) @(negedge clk);
    fsm_rst = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) run_row(rows[r]);
    repeat (5) @(negedge clk);
    $display(">>> PASS");
    $finish;
  end

endmodule
